/* all.f */
motorTimingPkg.sv
driveTypesPkg.sv
motorCmdIf.sv
signalSync.sv
pwmBank.sv
driveController.sv
bridgeOutput.sv
driveRobot.sv
driveRobot_properties.sv
tbDriveRobot.sv

/* bridgeOutput.sv */
module bridgeOutput import driveTypesPkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic [4:0] levels,
	motorCmdIf.drive   cmd,
	output logic       hbEnA,
	output logic       hbEnB,
	output logic [3:0] hbIn
);

	logic [3:0] pinCode;

	// PWM level for one enable, off and unused codes give zero
	function automatic logic levelFor(speedSelT sel, logic [4:0] lv);
		case (sel)
			speedFull: return lv[speedFull - 1];
			speedVeer: return lv[speedVeer - 1];
			speedHard: return lv[speedHard - 1];
			speedNinety: return lv[speedNinety - 1];
			speedNinetyFast: return lv[speedNinetyFast - 1];
			default: return 1'b0;
		endcase
	endfunction

	always_comb begin
		case (cmd.pattern)
			straightPat: pinCode = BRIDGE_STRAIGHT;
			leftPat: pinCode = BRIDGE_LEFT;
			rightPat: pinCode = BRIDGE_RIGHT;
			default: pinCode = BRIDGE_STOP;
		endcase
		// Reverse swaps both motor polarities
		if (cmd.travel == travelReverse && cmd.pattern != stopPat) begin
			pinCode = ~pinCode;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			hbEnA <= 1'b0;
			hbEnB <= 1'b0;
			hbIn <= BRIDGE_STOP;
		end else begin
			hbEnA <= levelFor(cmd.speedA, levels);
			hbEnB <= levelFor(cmd.speedB, levels);
			hbIn <= pinCode;
		end
	end

endmodule

/* driveController.sv */
module driveController import motorTimingPkg::*, driveTypesPkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  dirCmdT  dirCmd,
	input  toneT    tone,
	input  logic    colClear,
	motorCmdIf.ctrl cmd
);

	driveStateT state;
	logic [JNC_CNT_W-1:0] jncCnt;
	logic [JNC_CNT_W-1:0] jncLimit;
	logic jncDone;

	// Manoeuvre length follows the current tone
	always_comb begin
		case (tone)
			toneLeft, toneRight: jncLimit = JNC_CNT_W'(JNC_TURN_CYCLES);
			toneBack: jncLimit = JNC_CNT_W'(JNC_BACK_CYCLES);
			default: jncLimit = JNC_CNT_W'(JNC_STRAIGHT_CYCLES);
		endcase
	end

	// Also catches a tone switch to a shorter manoeuvre
	assign jncDone = (jncCnt >= jncLimit);

	////////////////////////////////////////////////////////////////////////////
	// Drive state machine
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= stateDrive;
			jncCnt <= '0;
			cmd.speedA <= speedOff;
			cmd.speedB <= speedOff;
			cmd.pattern <= stopPat;
			cmd.travel <= travelForwards;
		end else begin
			case (state)
				stateDrive: begin
					if (!colClear) begin
						state <= stateCollision;
						cmd.speedA <= speedOff;
						cmd.speedB <= speedOff;
					end else begin
						case (dirCmd.turn)
							turnLeft: begin
								case (dirCmd.rate)
									rateVeer: begin
										cmd.speedA <= speedVeer;
										cmd.speedB <= speedFull;
										cmd.pattern <= straightPat;
									end
									rateHard: begin
										cmd.speedA <= speedVeer;
										cmd.speedB <= speedHard;
										cmd.pattern <= leftPat;
									end
									rateStopTurn: begin
										cmd.speedA <= speedNinety;
										cmd.speedB <= speedNinetyFast;
										cmd.pattern <= leftPat;
									end
									default: ;
								endcase
							end
							turnRight: begin
								case (dirCmd.rate)
									rateVeer: begin
										cmd.speedA <= speedFull;
										cmd.speedB <= speedVeer;
										cmd.pattern <= straightPat;
									end
									rateHard: begin
										cmd.speedA <= speedHard;
										cmd.speedB <= speedVeer;
										cmd.pattern <= rightPat;
									end
									rateStopTurn: begin
										cmd.speedA <= speedNinetyFast;
										cmd.speedB <= speedNinety;
										cmd.pattern <= rightPat;
									end
									default: ;
								endcase
							end
							turnProceed: begin
								// Other rates keep the last command
								if (dirCmd.rate == rateFull) begin
									cmd.speedA <= speedFull;
									cmd.speedB <= speedFull;
									cmd.pattern <= straightPat;
								end
							end
							default: begin
								// Line lost, wait for a tone at the junction
								cmd.speedA <= speedOff;
								cmd.speedB <= speedOff;
								cmd.pattern <= stopPat;
								jncCnt <= '0;
								state <= stateJunction;
							end
						endcase
					end
				end

				stateCollision: begin
					cmd.speedA <= speedOff;
					cmd.speedB <= speedOff;
					if (colClear) begin
						state <= stateDrive;
					end
				end

				stateJunction: begin
					case (tone)
						toneStop: begin
							cmd.speedA <= speedOff;
							cmd.speedB <= speedOff;
							cmd.pattern <= stopPat;
						end
						toneStraight, toneBack: begin
							if (jncDone) begin
								jncCnt <= '0;
								state <= stateDrive;
								cmd.travel <= (tone == toneBack) ? travelReverse : travelForwards;
							end else begin
								jncCnt <= jncCnt + 1'b1;
								cmd.speedA <= speedFull;
								cmd.speedB <= speedFull;
								cmd.pattern <= straightPat;
							end
						end
						toneLeft, toneRight: begin
							if (!jncDone) begin
								jncCnt <= jncCnt + 1'b1;
								cmd.speedA <= (tone == toneLeft) ? speedNinety : speedNinetyFast;
								cmd.speedB <= (tone == toneLeft) ? speedNinetyFast : speedNinety;
								cmd.pattern <= (tone == toneLeft) ? leftPat : rightPat;
							end else if (dirCmd.turn == turnStop) begin
								// Turn is done but no line yet, so creep straight
								cmd.speedA <= speedFull;
								cmd.speedB <= speedFull;
								cmd.pattern <= straightPat;
							end else begin
								jncCnt <= '0;
								state <= stateDrive;
							end
						end
						default: begin
							jncCnt <= '0;
							state <= stateDrive;
							cmd.travel <= travelForwards;
						end
					endcase
				end

				default: state <= stateDrive;
			endcase
		end
	end

endmodule

/* driveRobot.sv */
module driveRobot import driveTypesPkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  turnT       dirTurn,
	input  rateT       dirRate,
	input  logic       colClear,
	input  toneT       toneDir,
	output logic       hbEnA,
	output logic       hbEnB,
	output logic [3:0] hbIn
);

	dirCmdT dirCmdRaw;
	dirCmdT dirCmdSync;
	toneT toneSync;
	logic colClearSync;
	logic [4:0] levels;

	motorCmdIf cmdBus ();

	// Turn and rate cross together
	assign dirCmdRaw.turn = dirTurn;
	assign dirCmdRaw.rate = dirRate;

	////////////////////////////////////////////////////////////////////////////
	// Input synchronizers
	////////////////////////////////////////////////////////////////////////////

	signalSync #(.payloadT(dirCmdT)) i_dirSync (
		.clk   (clk),
		.rst   (rst),
		.async (dirCmdRaw),
		.sync  (dirCmdSync)
	);

	signalSync #(.payloadT(toneT)) i_toneSync (
		.clk   (clk),
		.rst   (rst),
		.async (toneDir),
		.sync  (toneSync)
	);

	signalSync #(.payloadT(logic)) i_colSync (
		.clk   (clk),
		.rst   (rst),
		.async (colClear),
		.sync  (colClearSync)
	);

	////////////////////////////////////////////////////////////////////////////
	// Motion core
	////////////////////////////////////////////////////////////////////////////

	pwmBank i_pwmBank (
		.clk    (clk),
		.rst    (rst),
		.levels (levels)
	);

	driveController i_driveController (
		.clk      (clk),
		.rst      (rst),
		.dirCmd   (dirCmdSync),
		.tone     (toneSync),
		.colClear (colClearSync),
		.cmd      (cmdBus.ctrl)
	);

	bridgeOutput i_bridgeOutput (
		.clk    (clk),
		.rst    (rst),
		.levels (levels),
		.cmd    (cmdBus.drive),
		.hbEnA  (hbEnA),
		.hbEnB  (hbEnB),
		.hbIn   (hbIn)
	);

endmodule

/* driveRobot_properties.sv */
module driveRobot_properties import motorTimingPkg::*, driveTypesPkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  turnT       dirTurn,
	input  rateT       dirRate,
	input  logic       colClear,
	input  toneT       toneDir,
	input  logic       hbEnA,
	input  logic       hbEnB,
	input  logic [3:0] hbIn
);

	// Read by the testbench top
	int failCount = 0;

	logic proceedFull;
	logic condStraight;
	logic condVeerLeft;
	logic condHardRight;
	logic condJncStop;
	logic condReverse;
	logic colGuard;
	logic motorsOff;

	// Consecutive samples up to the previous edge
	int sinceRst;
	int straightRun;
	int veerLeftRun;
	int hardRightRun;
	int jncStopRun;
	int backRun;
	int reverseRun;
	int lowRun;
	int highRun;
	int lastLowLen;

	assign proceedFull = (dirTurn == turnProceed) && (dirRate == rateFull);
	assign condStraight = proceedFull && colClear && (toneDir != toneBack);
	assign condVeerLeft = (dirTurn == turnLeft) && (dirRate == rateVeer) && colClear
		&& (toneDir != toneBack);
	assign condHardRight = (dirTurn == turnRight) && (dirRate == rateHard) && colClear
		&& (toneDir != toneBack);
	assign condJncStop = (dirTurn == turnStop) && (toneDir == toneStop) && colClear;
	// Back manoeuvre finished with some margin
	assign condReverse = proceedFull && colClear && (backRun >= JNC_BACK_CYCLES + 20);
	// Low for five samples, or within five samples of clearing
	assign colGuard = (!colClear && lowRun >= 4)
		|| (colClear && highRun <= 4 && lastLowLen >= 5);
	assign motorsOff = !hbEnA && !hbEnB;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			sinceRst <= 0;
			straightRun <= 0;
			veerLeftRun <= 0;
			hardRightRun <= 0;
			jncStopRun <= 0;
			backRun <= 0;
			reverseRun <= 0;
			lowRun <= 0;
			highRun <= 0;
			lastLowLen <= 0;
		end else begin
			sinceRst <= sinceRst + 1;
			straightRun <= condStraight ? straightRun + 1 : 0;
			veerLeftRun <= condVeerLeft ? veerLeftRun + 1 : 0;
			hardRightRun <= condHardRight ? hardRightRun + 1 : 0;
			jncStopRun <= condJncStop ? jncStopRun + 1 : 0;
			backRun <= (toneDir == toneBack) ? backRun + 1 : 0;
			reverseRun <= condReverse ? reverseRun + 1 : 0;
			if (colClear) begin
				highRun <= highRun + 1;
				lowRun <= 0;
			end else begin
				highRun <= 0;
				lowRun <= lowRun + 1;
				lastLowLen <= lowRun + 1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Output checks, four cycles of latency plus the sampling edge
	////////////////////////////////////////////////////////////////////////////

	resetQuiet: assert property (@(posedge clk)
		(rst || sinceRst < 4) |-> (motorsOff && hbIn == BRIDGE_STOP))
	else begin
		failCount++;
		$error("Error resetQuiet: expected enables 0 0 hbIn %b, actual %b %b hbIn %b",
			BRIDGE_STOP, $sampled(hbEnA), $sampled(hbEnB), $sampled(hbIn));
	end

	straightDrive: assert property (@(posedge clk) disable iff (rst)
		(condStraight && straightRun >= 4) |-> (hbIn == BRIDGE_STRAIGHT && hbEnA == hbEnB))
	else begin
		failCount++;
		$error("Error straightDrive: expected hbIn %b equal enables, actual hbIn %b enA %b enB %b",
			BRIDGE_STRAIGHT, $sampled(hbIn), $sampled(hbEnA), $sampled(hbEnB));
	end

	veerLeft: assert property (@(posedge clk) disable iff (rst)
		(condVeerLeft && veerLeftRun >= 4) |-> (hbIn == BRIDGE_STRAIGHT && (!hbEnA || hbEnB)))
	else begin
		failCount++;
		$error("Error veerLeft: expected hbIn %b enA implies enB, actual hbIn %b enA %b enB %b",
			BRIDGE_STRAIGHT, $sampled(hbIn), $sampled(hbEnA), $sampled(hbEnB));
	end

	hardRight: assert property (@(posedge clk) disable iff (rst)
		(condHardRight && hardRightRun >= 4) |-> (hbIn == BRIDGE_RIGHT && (!hbEnB || hbEnA)))
	else begin
		failCount++;
		$error("Error hardRight: expected hbIn %b enB implies enA, actual hbIn %b enA %b enB %b",
			BRIDGE_RIGHT, $sampled(hbIn), $sampled(hbEnA), $sampled(hbEnB));
	end

	collisionOff: assert property (@(posedge clk) disable iff (rst)
		colGuard |-> motorsOff)
	else begin
		failCount++;
		$error("Error collisionOff: expected enables 0 0, actual %b %b",
			$sampled(hbEnA), $sampled(hbEnB));
	end

	junctionStop: assert property (@(posedge clk) disable iff (rst)
		(condJncStop && jncStopRun >= 4) |-> (motorsOff && hbIn == BRIDGE_STOP))
	else begin
		failCount++;
		$error("Error junctionStop: expected enables 0 0 hbIn %b, actual %b %b hbIn %b",
			BRIDGE_STOP, $sampled(hbEnA), $sampled(hbEnB), $sampled(hbIn));
	end

	reverseDrive: assert property (@(posedge clk) disable iff (rst)
		(condReverse && reverseRun >= 4) |-> (hbIn == ~BRIDGE_STRAIGHT))
	else begin
		failCount++;
		$error("Error reverseDrive: expected hbIn %b, actual hbIn %b",
			~BRIDGE_STRAIGHT, $sampled(hbIn));
	end

endmodule

/* driveTypesPkg.sv */
package driveTypesPkg;

	////////////////////////////////////////////////////////////////////////////
	// Commands from the sensing side
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		turnProceed = 2'b00,
		turnLeft = 2'b01,
		turnRight = 2'b10,
		turnStop = 2'b11
	} turnT;

	typedef enum logic [1:0] {
		rateFull = 2'b00,
		rateVeer = 2'b01,
		rateHard = 2'b10,
		rateStopTurn = 2'b11
	} rateT;

	// Turn in the upper bits, rate in the lower
	typedef struct packed {
		turnT turn;
		rateT rate;
	} dirCmdT;

	typedef enum logic [2:0] {
		toneStraight = 3'd0,
		toneLeft = 3'd1,
		toneRight = 3'd2,
		toneBack = 3'd3,
		toneStop = 3'd4
	} toneT;

	////////////////////////////////////////////////////////////////////////////
	// Motion control
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		stateDrive = 2'b00,
		stateCollision = 2'b10,
		stateJunction = 2'b11
	} driveStateT;

	// Level bus bit is the code minus one
	typedef enum logic [2:0] {
		speedOff = 3'd0,
		speedFull = 3'd1,
		speedVeer = 3'd2,
		speedHard = 3'd3,
		speedNinety = 3'd4,
		speedNinetyFast = 3'd5
	} speedSelT;

	typedef enum logic [1:0] {
		stopPat = 2'd0,
		straightPat = 2'd1,
		leftPat = 2'd2,
		rightPat = 2'd3
	} bridgePatT;

	typedef enum logic {
		travelReverse = 1'b0,
		travelForwards = 1'b1
	} travelT;

	// H-bridge input pin codes, pin 4 in the MSB
	localparam logic [3:0] BRIDGE_STRAIGHT = 4'b0110;
	localparam logic [3:0] BRIDGE_LEFT = 4'b0101;
	localparam logic [3:0] BRIDGE_RIGHT = 4'b1010;
	localparam logic [3:0] BRIDGE_STOP = 4'b0000;

endpackage

/* motorCmdIf.sv */
interface motorCmdIf import driveTypesPkg::*; ();

	// Speed level per enable pin
	speedSelT speedA;
	speedSelT speedB;
	bridgePatT pattern;
	travelT travel;

	// State machine side
	modport ctrl (
		output speedA, speedB, pattern, travel
	);

	// Output stage side
	modport drive (
		input speedA, speedB, pattern, travel
	);

endinterface

/* motorTimingPkg.sv */
package motorTimingPkg;

	////////////////////////////////////////////////////////////////////////////
	// PWM timing
	////////////////////////////////////////////////////////////////////////////

	// Clocks per PWM cycle, shared by every speed level
	localparam int PWM_PERIOD = 100;
	localparam int PWM_CNT_W = $clog2(PWM_PERIOD);

	// On-counts per speed level
	localparam logic [PWM_CNT_W-1:0] DUTY_FULL = PWM_CNT_W'(60);
	localparam logic [PWM_CNT_W-1:0] DUTY_VEER = PWM_CNT_W'(30);
	localparam logic [PWM_CNT_W-1:0] DUTY_HARD = PWM_CNT_W'(80);
	localparam logic [PWM_CNT_W-1:0] DUTY_NINETY = PWM_CNT_W'(40);
	localparam logic [PWM_CNT_W-1:0] DUTY_NINETY_FAST = PWM_CNT_W'(45);

	////////////////////////////////////////////////////////////////////////////
	// Junction manoeuvres
	////////////////////////////////////////////////////////////////////////////

	localparam int JNC_STRAIGHT_CYCLES = 200;
	localparam int JNC_TURN_CYCLES = 300;
	localparam int JNC_BACK_CYCLES = 200;
	// Sized for the longest manoeuvre
	localparam int JNC_CNT_W = $clog2(JNC_TURN_CYCLES + 1);

	// Input synchronizer depth
	localparam int SYNC_STAGES = 2;

endpackage

/* pwmBank.sv */
module pwmBank import motorTimingPkg::*, driveTypesPkg::*; (
	input  logic       clk,
	input  logic       rst,
	output logic [4:0] levels
);

	logic [PWM_CNT_W-1:0] periodCnt;

	// Shared period counter
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			periodCnt <= '0;
		end else if (periodCnt == PWM_CNT_W'(PWM_PERIOD - 1)) begin
			periodCnt <= '0;
		end else begin
			periodCnt <= periodCnt + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Duty compares
	////////////////////////////////////////////////////////////////////////////

	// All levels rise together at count zero
	assign levels[speedFull - 1] = (periodCnt < DUTY_FULL);
	assign levels[speedVeer - 1] = (periodCnt < DUTY_VEER);
	assign levels[speedHard - 1] = (periodCnt < DUTY_HARD);
	assign levels[speedNinety - 1] = (periodCnt < DUTY_NINETY);
	assign levels[speedNinetyFast - 1] = (periodCnt < DUTY_NINETY_FAST);

endmodule

/* runSim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tbDriveRobot -f all.f -o simDriveRobot
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build exited with status $status"
	exit "$status"
fi

# Let every assertion message print before the testbench stops the run
./obj_dir/simDriveRobot +verilator+error+limit+100
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulator exited with status $status"
fi
exit "$status"

/* signalSync.sv */
module signalSync import motorTimingPkg::*; #(
	parameter type payloadT = logic
) (
	input  logic    clk,
	input  logic    rst,
	input  payloadT async,
	output payloadT sync
);

	payloadT stages [SYNC_STAGES];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < SYNC_STAGES; i++) begin
				stages[i] <= payloadT'(0);
			end
		end else begin
			stages[0] <= async;
			for (int i = 1; i < SYNC_STAGES; i++) begin
				stages[i] <= stages[i-1];
			end
		end
	end

	assign sync = stages[SYNC_STAGES-1];

endmodule

/* tbDriveRobot.sv */
module tbDriveRobot import motorTimingPkg::*, driveTypesPkg::*; ();

	logic clk;
	logic rst;
	turnT dirTurn;
	rateT dirRate;
	logic colClear;
	toneT toneDir;
	logic hbEnA;
	logic hbEnB;
	logic [3:0] hbIn;

	driveRobot i_driveRobot (
		.clk      (clk),
		.rst      (rst),
		.dirTurn  (dirTurn),
		.dirRate  (dirRate),
		.colClear (colClear),
		.toneDir  (toneDir),
		.hbEnA    (hbEnA),
		.hbEnB    (hbEnB),
		.hbIn     (hbIn)
	);

	// Checkers sit inside the DUT
	bind driveRobot driveRobot_properties i_props (
		.clk      (clk),
		.rst      (rst),
		.dirTurn  (dirTurn),
		.dirRate  (dirRate),
		.colClear (colClear),
		.toneDir  (toneDir),
		.hbEnA    (hbEnA),
		.hbEnB    (hbEnB),
		.hbIn     (hbIn)
	);

	always #5 clk = ~clk;

	// Stop at the first failed assertion
	always @(negedge clk) begin
		if (i_driveRobot.i_props.failCount != 0) begin
			$display("Simulation failed");
			$fatal(1, "An assertion on the DUT outputs failed");
		end
	end

	task automatic nextCycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic setInputs(input turnT turn, input rateT rate, input logic clear,
		input toneT tone);
		dirTurn = turn;
		dirRate = rate;
		colClear = clear;
		toneDir = tone;
	endtask

	task automatic waitForPins(input logic [3:0] code, input int limit);
		int count;
		count = 0;
		while (hbIn !== code) begin
			if (count >= limit) begin
				$display("Simulation failed");
				$fatal(1, "Timed out waiting for bridge pins %b", code);
			end
			@(posedge clk);
			#1;
			count++;
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		// Proceed at veer keeps the last command, so the motors stay off
		setInputs(turnProceed, rateVeer, 1'b1, toneStraight);
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		nextCycles(10);

		setInputs(turnProceed, rateFull, 1'b1, toneStraight);
		nextCycles(PWM_PERIOD + 10);

		// Bump while driving straight
		setInputs(turnProceed, rateFull, 1'b0, toneStraight);
		nextCycles(20);
		setInputs(turnProceed, rateFull, 1'b1, toneStraight);
		nextCycles(20);

		setInputs(turnLeft, rateVeer, 1'b1, toneStraight);
		nextCycles(PWM_PERIOD + 10);
		setInputs(turnRight, rateHard, 1'b1, toneStraight);
		nextCycles(PWM_PERIOD + 10);

		// Line lost at a junction
		setInputs(turnStop, rateFull, 1'b1, toneStop);
		nextCycles(20);

		// Turn around, then follow the line in reverse
		setInputs(turnStop, rateFull, 1'b1, toneBack);
		waitForPins(~BRIDGE_STRAIGHT, JNC_BACK_CYCLES + 50);
		nextCycles(30);
		setInputs(turnProceed, rateFull, 1'b1, toneBack);
		// Repeated back run ends, then proceed drives on in reverse
		nextCycles(JNC_BACK_CYCLES + 20);

		if (i_driveRobot.i_props.failCount == 0) begin
			$display("Simulation passed");
			$finish;
		end else begin
			$display("Simulation failed");
			$fatal(1, "Assertion failures were reported");
		end
	end

endmodule
